// ==== Makefile ====
# Verilator build and run of the decode stage testbench

VERILATOR   ?= verilator
TOP         ?= decode_tb
FILELIST    ?= list.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
PASS_STRING ?= Test completed successfully
VFLAGS      ?= --binary --timing --assert -Wall

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_STRING)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/decode_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_assert
    import decode_pkg::*;
(
    input wire logic     clk_stage,
    input wire logic     rst,
    input wire logic     stage_en,
    input wire logic     hold,
    input wire decoded_t decoded
);

    // A stalled slot reaches EXE as a bubble
    hold_gives_bubble: assert property (
        @(posedge clk_stage) disable iff (!rst)
        (hold && stage_en) |=> !decoded.valid
    ) else $error("bundle after a hold is valid");

    // Stage buffer frozen under back-pressure
    stall_keeps_bundle: assert property (
        @(posedge clk_stage) disable iff (!rst)
        !stage_en |=> $stable(decoded)
    ) else $error("bundle changed while stage_en was low");

    reset_clears_bundle: assert property (
        @(posedge clk_stage)
        !rst |-> (decoded == '0)
    ) else $error("bundle not zero during reset");

endmodule

bind decode_stage decode_assert i_decode_assert (
    .clk_stage (clk_stage),
    .rst       (rst),
    .stage_en  (stage_en),
    .hold      (hold),
    .decoded   (decoded)
);

`default_nettype wire

// ==== dv/decode_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_tb
    import decode_pkg::*;
();

    // Reset 4 cycles, alu_decode 58, operands 9, forwarding 10
    // Load-use 6 cycles and back-pressure 7
    localparam int total_cycles  = 94;
    // The watchdog allows twice the stimulus length
    localparam int timeout_limit = 2 * total_cycles;

    logic                 clk_stage = 1'b0;
    logic                 rst;
    logic                 stage_en;
    logic [xlen-1:0]      instr;
    logic [xlen-1:0]      pc;
    logic [xlen-1:0]      rf_data1;
    logic [xlen-1:0]      rf_data2;
    fwd_src_t             exe_fwd;
    fwd_src_t             mem_fwd;
    fwd_src_t             wb_fwd;
    logic [xlen-1:0]      exe_result;
    logic [xlen-1:0]      mem_result;
    logic [reg_idx_w-1:0] rs1;
    logic [reg_idx_w-1:0] rs2;
    logic                 hold;
    decoded_t             decoded;

    // Expected state, set by the driver and the model register
    decoded_t    exp_next;
    decoded_t    exp_q;
    logic        exp_hold;
    logic        drv_en;
    logic [15:0] lfsr;
    string       cur_test;
    int          errors;
    int          test_errors;
    int          checks;
    int          cycles;
    logic [6:0]  opc_table [10];

    decode_stage i_decode_stage (
        .clk_stage  (clk_stage),
        .rst        (rst),
        .stage_en   (stage_en),
        .instr      (instr),
        .pc         (pc),
        .rf_data1   (rf_data1),
        .rf_data2   (rf_data2),
        .exe_fwd    (exe_fwd),
        .mem_fwd    (mem_fwd),
        .wb_fwd     (wb_fwd),
        .exe_result (exe_result),
        .mem_result (mem_result),
        .rs1        (rs1),
        .rs2        (rs2),
        .hold       (hold),
        .decoded    (decoded)
    );

    always #4 clk_stage = ~clk_stage;

    // Register file contents as a fixed pattern of the index
    function automatic logic [31:0] rf_model(input logic [4:0] idx);
        return (32'(idx) * 32'h0001_0203) ^ 32'h5A00_0000;
    endfunction

    function automatic fwd_src_t fwd(input logic [4:0] dest, input logic ld);
        fwd_src_t f;
        f.dest    = dest;
        f.is_load = ld;
        return f;
    endfunction

    function automatic logic [31:0] enc(input logic [6:0] f7, input logic [4:0] r2,
        input logic [4:0] r1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
        return {f7, r2, r1, f3, rd, opc};
    endfunction

    // Operand value after the forwarding priority
    function automatic logic [31:0] src_val(input logic [4:0] idx, input fwd_src_t e,
        input fwd_src_t m, input logic [31:0] er, input logic [31:0] mr);
        if (idx == 0) return 32'h0;
        if (e.dest == idx) return er;
        if (m.dest == idx) return mr;
        return rf_model(idx);
    endfunction

    function automatic alu_op_e alu_ref(input logic [2:0] f3, input logic alt, input logic rf);
        case (f3)
            3'd0: return (rf && alt) ? alu_sub : alu_add;
            3'd1: return alu_sll;
            3'd2, 3'd3: return alu_sub;
            3'd4: return alu_xor;
            3'd5: return alt ? alu_sra : alu_srl;
            3'd6: return alu_or;
            default: return alu_and;
        endcase
    endfunction

    // Expected bundle for one instruction, before any hold
    function automatic decoded_t ref_decode(input logic [31:0] ins, input logic [31:0] pcv,
        input fwd_src_t e, input fwd_src_t m, input logic [31:0] er, input logic [31:0] mr);
        decoded_t    d;
        logic [31:0] v1;
        logic [31:0] v2;
        logic [31:0] imm_i;
        logic [2:0]  f3;
        v1    = src_val(ins[19:15], e, m, er, mr);
        v2    = src_val(ins[24:20], e, m, er, mr);
        imm_i = {{20{ins[31]}}, ins[31:20]};
        f3    = ins[14:12];
        d     = '0;
        d.valid = 1'b1;
        d.pc    = pcv;
        d.dest  = ins[11:7];
        d.opr1  = v1;
        case (ins[6:0])
            7'h33: begin
                d.alu_op = alu_ref(f3, ins[30], 1'b1);
                d.sgn    = (f3 == 3'd2) || (f3 == 3'd5 && ins[30]);
                d.opr2   = v2;
            end
            7'h13: begin
                d.alu_op = alu_ref(f3, ins[30], 1'b0);
                d.sgn    = (f3 == 3'd2) || (f3 == 3'd5 && ins[30]);
                d.opr2   = imm_i;
            end
            7'h37: begin
                d.opr1 = '0;
                d.opr2 = {ins[31:12], 12'b0};
            end
            7'h17: begin
                d.opr1 = pcv;
                d.opr2 = {ins[31:12], 12'b0};
            end
            7'h6F: begin
                d.opr1 = pcv;
                d.opr2 = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            7'h67: d.opr2 = imm_i;
            7'h63: begin
                d.is_branch   = 1'b1;
                d.dest        = '0;
                d.alu_op      = f3[2] ? alu_sub : alu_xor;
                d.sgn         = (f3 == 3'd4) || (f3 == 3'd5);
                d.branch_cond = (f3 == 3'd1) ? br_ne : !f3[2] ? br_eq : f3[0] ? br_ge : br_lt;
                d.opr2        = v2;
            end
            7'h03: begin
                d.is_load = 1'b1;
                d.opr2    = imm_i;
            end
            7'h23: begin
                d.dest       = '0;
                d.opr2       = {{20{ins[31]}}, ins[31:25], ins[11:7]};
                d.store_data = v2;
            end
            // Illegal opcode gives a bubble
            default: d = '0;
        endcase
        return d;
    endfunction

    function automatic logic ref_hold(input logic [31:0] ins, input fwd_src_t e);
        logic used1;
        logic used2;
        logic [6:0] o;
        o     = ins[6:0];
        used1 = o inside {7'h33, 7'h13, 7'h67, 7'h63, 7'h03, 7'h23};
        used2 = o inside {7'h33, 7'h63, 7'h23};
        return e.is_load && ((used1 && ins[19:15] != 0 && ins[19:15] == e.dest)
            || (used2 && ins[24:20] != 0 && ins[24:20] == e.dest));
    endfunction

    // Fibonacci LFSR, taps 16 14 13 11, one step per bit taken
    task automatic next_bits(input int n, output logic [31:0] v);
        logic b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], b};
            v    = {v[30:0], b};
        end
    endtask

    // One stimulus cycle, driven just after the rising edge
    task automatic apply(input logic [31:0] ins, input logic [31:0] pcv, input fwd_src_t e,
        input fwd_src_t m, input fwd_src_t w, input logic [31:0] er, input logic [31:0] mr,
        input logic en);
        @(posedge clk_stage);
        #1;
        instr      = ins;
        pc         = pcv;
        exe_fwd    = e;
        mem_fwd    = m;
        wb_fwd     = w;
        exe_result = er;
        mem_result = mr;
        rf_data1   = rf_model(ins[19:15]);
        rf_data2   = rf_model(ins[24:20]);
        stage_en   = en;
        drv_en     = en;
        exp_next   = ref_decode(ins, pcv, e, m, er, mr);
        exp_hold   = ref_hold(ins, e);
    endtask

    // Simple case with no downstream matches
    task automatic apply_plain(input logic [31:0] ins);
        apply(ins, 32'h0000_1000, fwd(5'd0, 1'b0), fwd(5'd0, 1'b0), fwd(5'd0, 1'b0),
            32'hEEEE_0001, 32'hDDDD_0002, 1'b1);
    endtask

    task automatic end_test();
        @(posedge clk_stage);
        @(negedge clk_stage);
        // Let the compare of this edge finish first
        #1;
        $display("%s: done, %0d errors", cur_test, errors - test_errors);
        test_errors = errors;
    endtask

    // Model of the stage buffer
    always @(posedge clk_stage or negedge rst) begin
        if (!rst) begin
            exp_q = '0;
        end else if (drv_en) begin
            exp_q = exp_hold ? '0 : exp_next;
        end
    end

    // Compare on the falling edge where outputs are settled
    always @(negedge clk_stage) begin
        checks++;
        if (decoded !== exp_q) begin
            errors++;
            $display("[ERROR] %s decoded expected %h actual %h", cur_test, exp_q, decoded);
        end
        if (hold !== exp_hold) begin
            errors++;
            $display("[ERROR] %s hold expected %b actual %b", cur_test, exp_hold, hold);
        end
        // Register file read ports carry the raw source fields
        if (rs1 !== instr[19:15]) begin
            errors++;
            $display("[ERROR] %s rs1 expected %h actual %h", cur_test, instr[19:15], rs1);
        end
        if (rs2 !== instr[24:20]) begin
            errors++;
            $display("[ERROR] %s rs2 expected %h actual %h", cur_test, instr[24:20], rs2);
        end
    end

    always @(posedge clk_stage) begin
        cycles++;
        if (cycles > timeout_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] ins;
        logic [31:0] d;
        rst = 1'b0;
        stage_en = 1'b0;
        instr = '0;
        pc = '0;
        rf_data1 = '0;
        rf_data2 = '0;
        exe_fwd = '0;
        mem_fwd = '0;
        wb_fwd = '0;
        exe_result = '0;
        mem_result = '0;
        drv_en = 1'b0;
        exp_next = '0;
        exp_q = '0;
        exp_hold = 1'b0;
        lfsr = 16'd11;
        errors = 0;
        test_errors = 0;
        checks = 0;
        cycles = 0;
        opc_table = '{7'h33, 7'h13, 7'h37, 7'h17, 7'h6F, 7'h67, 7'h63, 7'h03, 7'h23, 7'h7F};
        cur_test = "reset";
        // A legal word with stage_en high must not get past reset
        repeat (3) begin
            apply_plain(enc(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, 7'h33));
        end
        rst = 1'b1;
        end_test();

        cur_test = "alu_decode";
        apply_plain(enc(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, 7'h33));
        apply_plain(enc(7'h20, 5'd2, 5'd1, 3'd0, 5'd3, 7'h33));
        apply_plain(enc(7'h00, 5'd2, 5'd1, 3'd2, 5'd4, 7'h33));
        apply_plain(enc(7'h00, 5'd2, 5'd1, 3'd3, 5'd4, 7'h33));
        apply_plain(enc(7'h20, 5'd2, 5'd1, 3'd5, 5'd5, 7'h33));
        apply_plain(enc(7'h20, 5'd3, 5'd1, 3'd5, 5'd6, 7'h13));
        apply_plain(enc(7'h00, 5'd3, 5'd1, 3'd1, 5'd6, 7'h13));
        apply_plain(enc(7'h7F, 5'd31, 5'd1, 3'd4, 5'd7, 7'h13));
        apply_plain(enc(7'h20, 5'd2, 5'd1, 3'd0, 5'd7, 7'h13));
        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) apply_plain(enc(7'h41, 5'd2, 5'd1, 3'(f), 5'd9, 7'h63));
        end
        apply_plain(enc(7'h12, 5'd3, 5'd4, 3'd5, 5'd8, 7'h67));
        apply_plain(enc(7'h55, 5'd3, 5'd4, 3'd5, 5'd8, 7'h7F));
        for (int i = 0; i < 40; i++) begin
            next_bits(4, r);
            next_bits(25, ins);
            ins = {ins[24:0], opc_table[r % 10]};
            next_bits(6, r);
            ins[19:15] = {2'b00, r[2:0]};
            ins[24:20] = {2'b00, r[5:3]};
            // Keep branch funct3 to the defined encodings
            if (ins[6:0] == 7'h63 && ins[14:13] == 2'b01) ins[14] = 1'b1;
            next_bits(11, r);
            next_bits(32, d);
            apply(ins, d, fwd({2'b00, r[2:0]}, r[9]), fwd({2'b00, r[5:3]}, 1'b0),
                fwd({2'b00, r[8:6]}, 1'b0), d ^ 32'h1111_1111, d ^ 32'h2222_2222,
                r[10] | r[0]);
        end
        end_test();

        cur_test = "operands";
        apply_plain(enc(7'h00, 5'd7, 5'd6, 3'd0, 5'd1, 7'h33));
        apply_plain(enc(7'h7F, 5'd30, 5'd6, 3'd0, 5'd1, 7'h13));
        apply_plain(enc(7'h5A, 5'd15, 5'd6, 3'd3, 5'd2, 7'h37));
        apply_plain(enc(7'h5A, 5'd15, 5'd6, 3'd3, 5'd2, 7'h17));
        apply_plain(enc(7'h4B, 5'd21, 5'd9, 3'd6, 5'd2, 7'h6F));
        apply_plain(enc(7'h7F, 5'd1, 5'd6, 3'd0, 5'd2, 7'h67));
        apply_plain(enc(7'h40, 5'd7, 5'd6, 3'd2, 5'd3, 7'h03));
        apply_plain(enc(7'h6A, 5'd7, 5'd6, 3'd2, 5'h15, 7'h23));
        end_test();

        cur_test = "forwarding";
        for (int mask = 0; mask < 8; mask++) begin
            apply(enc(7'h00, 5'd5, 5'd5, 3'd0, 5'd1, 7'h33), 32'h2000,
                fwd(mask[0] ? 5'd5 : 5'd9, 1'b0), fwd(mask[1] ? 5'd5 : 5'd10, 1'b0),
                fwd(mask[2] ? 5'd5 : 5'd11, 1'b0), 32'hAAAA_0005, 32'hBBBB_0005, 1'b1);
        end
        apply(enc(7'h00, 5'd0, 5'd0, 3'd0, 5'd1, 7'h33), 32'h2004, fwd(5'd0, 1'b0),
            fwd(5'd0, 1'b0), fwd(5'd0, 1'b0), 32'hAAAA_0000, 32'hBBBB_0000, 1'b1);
        end_test();

        cur_test = "load_use";
        apply(enc(7'h00, 5'd1, 5'd3, 3'd0, 5'd4, 7'h33), 32'h3000, fwd(5'd3, 1'b1),
            fwd(5'd0, 1'b0), fwd(5'd0, 1'b0), 32'h0, 32'h0, 1'b1);
        apply(enc(7'h00, 5'd3, 5'd1, 3'd0, 5'd4, 7'h33), 32'h3000, fwd(5'd3, 1'b1),
            fwd(5'd0, 1'b0), fwd(5'd0, 1'b0), 32'h0, 32'h0, 1'b1);
        apply(enc(7'h00, 5'd3, 5'd3, 3'd0, 5'd4, 7'h37), 32'h3004, fwd(5'd3, 1'b1),
            fwd(5'd0, 1'b0), fwd(5'd0, 1'b0), 32'h0, 32'h0, 1'b1);
        apply(enc(7'h00, 5'd3, 5'd1, 3'd0, 5'd4, 7'h13), 32'h3008, fwd(5'd3, 1'b1),
            fwd(5'd0, 1'b0), fwd(5'd0, 1'b0), 32'h0, 32'h0, 1'b1);
        apply(enc(7'h00, 5'd0, 5'd0, 3'd0, 5'd4, 7'h33), 32'h300C, fwd(5'd0, 1'b1),
            fwd(5'd0, 1'b0), fwd(5'd0, 1'b0), 32'h0, 32'h0, 1'b1);
        end_test();

        cur_test = "back_pressure";
        ins = enc(7'h20, 5'd8, 5'd7, 3'd0, 5'd2, 7'h33);
        apply(ins, 32'h4000, fwd(5'd0, 1'b0), fwd(5'd0, 1'b0), fwd(5'd0, 1'b0),
            32'h0, 32'h0, 1'b1);
        for (int i = 0; i < 4; i++) begin
            apply(ins, 32'h4000, fwd(5'd7, 1'b0), fwd(5'd8, 1'b0), fwd(5'd0, 1'b0),
                32'h100 + i, 32'h200 + i, 1'b0);
        end
        apply(enc(7'h00, 5'd3, 5'd7, 3'd6, 5'd9, 7'h13), 32'h4004, fwd(5'd7, 1'b0),
            fwd(5'd0, 1'b0), fwd(5'd0, 1'b0), 32'h0000_0777, 32'h0, 1'b1);
        end_test();

        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
logic/decode_pkg.sv
logic/decode_control.sv
logic/imm_gen.sv
logic/operand_forward.sv
logic/decode_stage_reg.sv
logic/decode_stage.sv
dv/decode_assert.sv
dv/decode_tb.sv

// ==== logic/decode_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_control
    import decode_pkg::*;
(
    input  wire logic [xlen-1:0] instr,
    output ctrl_t                ctrl
);

    opcode_e              opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    logic [reg_idx_w-1:0] rd;
    logic                 shift_right;

    // Non-matching opcode values fall into the default branch below
    assign opcode      = opcode_e'(instr[6:0]);
    assign funct3      = instr[14:12];
    assign funct7      = instr[31:25];
    assign rd          = instr[11:7];
    assign shift_right = (funct3 == f3_srl_sra);

    // ALU table shared by op and op_imm
    // Sub only exists in the register form, funct7[5] picks sra in both
    function automatic alu_op_e arith_op(
        input logic [2:0] f3,
        input logic       alt,
        input logic       reg_form
    );
        alu_op_e res;
        case (f3)
            f3_add_sub:      res = (reg_form && alt) ? alu_sub : alu_add;
            f3_sll:          res = alu_sll;
            // Set-less-than is a compare done by subtraction
            f3_slt, f3_sltu: res = alu_sub;
            f3_xor:          res = alu_xor;
            f3_srl_sra:      res = alt ? alu_sra : alu_srl;
            f3_or:           res = alu_or;
            default:         res = alu_and;
        endcase
        return res;
    endfunction

    always_comb begin
        // Illegal words keep this all-zero default, valid stays low
        ctrl = '0;
        case (opcode)
            op: begin
                ctrl.alu_op   = arith_op(funct3, funct7[5], 1'b1);
                ctrl.sgn      = (funct3 == f3_slt) || (shift_right && funct7[5]);
                ctrl.opa_sel  = opa_rs1;
                ctrl.opb_sel  = opb_rs2;
                ctrl.rs1_used = 1'b1;
                ctrl.rs2_used = 1'b1;
                ctrl.dest     = rd;
                ctrl.valid    = 1'b1;
            end
            op_imm: begin
                ctrl.alu_op   = arith_op(funct3, funct7[5], 1'b0);
                ctrl.sgn      = (funct3 == f3_slt) || (shift_right && funct7[5]);
                ctrl.opa_sel  = opa_rs1;
                ctrl.opb_sel  = opb_imm;
                ctrl.rs1_used = 1'b1;
                ctrl.dest     = rd;
                ctrl.valid    = 1'b1;
            end
            // Upper immediate goes through the adder with zero on operand one
            lui: begin
                ctrl.opa_sel = opa_zero;
                ctrl.opb_sel = opb_imm;
                ctrl.dest    = rd;
                ctrl.valid   = 1'b1;
            end
            auipc, jal: begin
                ctrl.opa_sel = opa_pc;
                ctrl.opb_sel = opb_imm;
                ctrl.dest    = rd;
                ctrl.valid   = 1'b1;
            end
            jalr: begin
                ctrl.opa_sel  = opa_rs1;
                ctrl.opb_sel  = opb_imm;
                ctrl.rs1_used = 1'b1;
                ctrl.dest     = rd;
                ctrl.valid    = 1'b1;
            end
            branch: begin
                // Equality by xor, ordering by sub
                case (funct3)
                    f3_bne:           ctrl.branch_cond = br_ne;
                    f3_blt, f3_bltu:  ctrl.branch_cond = br_lt;
                    f3_bge, f3_bgeu:  ctrl.branch_cond = br_ge;
                    default:          ctrl.branch_cond = br_eq;
                endcase
                ctrl.alu_op    = funct3[2] ? alu_sub : alu_xor;
                ctrl.sgn       = (funct3 == f3_blt) || (funct3 == f3_bge);
                ctrl.is_branch = 1'b1;
                ctrl.opa_sel   = opa_rs1;
                ctrl.opb_sel   = opb_rs2;
                ctrl.rs1_used  = 1'b1;
                ctrl.rs2_used  = 1'b1;
                ctrl.valid     = 1'b1;
            end
            // Address is base plus offset
            load: begin
                ctrl.is_load  = 1'b1;
                ctrl.opa_sel  = opa_rs1;
                ctrl.opb_sel  = opb_imm;
                ctrl.rs1_used = 1'b1;
                ctrl.dest     = rd;
                ctrl.valid    = 1'b1;
            end
            store: begin
                ctrl.is_store = 1'b1;
                ctrl.opa_sel  = opa_rs1;
                ctrl.opb_sel  = opb_imm;
                ctrl.rs1_used = 1'b1;
                ctrl.rs2_used = 1'b1;
                ctrl.valid    = 1'b1;
            end
            default: begin
                ctrl.valid = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

    // RV32I data and address width
    localparam int xlen = 32;
    // Register index width, x0 to x31
    localparam int reg_idx_w = 5;

    // funct3 codes of the integer ALU instructions
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;

    // funct3 codes of the conditional branches
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // Major opcodes, instruction bits [6:0]
    typedef enum logic [6:0] {
        op     = 7'b0110011,
        op_imm = 7'b0010011,
        lui    = 7'b0110111,
        auipc  = 7'b0010111,
        jal    = 7'b1101111,
        jalr   = 7'b1100111,
        branch = 7'b1100011,
        load   = 7'b0000011,
        store  = 7'b0100011
    } opcode_e;

    // ALU operations, add is the all-zero default
    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_sll = 3'd5,
        alu_srl = 3'd6,
        alu_sra = 3'd7
    } alu_op_e;

    // Branch condition, signedness travels separately in sgn
    typedef enum logic [1:0] {
        br_eq = 2'd0,
        br_ne = 2'd1,
        br_lt = 2'd2,
        br_ge = 2'd3
    } branch_cond_e;

    typedef enum logic [1:0] {
        opa_rs1  = 2'd0,
        opa_zero = 2'd1,
        opa_pc   = 2'd2
    } opa_sel_e;

    typedef enum logic [0:0] {
        opb_rs2 = 1'b0,
        opb_imm = 1'b1
    } opb_sel_e;

    // Destination record of one downstream stage
    typedef struct packed {
        logic [reg_idx_w-1:0] dest;
        // Only looked at for EXE
        logic                 is_load;
    } fwd_src_t;

    // Control decisions for the current instruction word
    typedef struct packed {
        alu_op_e              alu_op;
        logic                 sgn;
        logic                 is_branch;
        branch_cond_e         branch_cond;
        logic                 is_load;
        logic                 is_store;
        opa_sel_e             opa_sel;
        opb_sel_e             opb_sel;
        logic                 rs1_used;
        logic                 rs2_used;
        logic [reg_idx_w-1:0] dest;
        logic                 valid;
    } ctrl_t;

    // Registered bundle handed to the execute stage
    typedef struct packed {
        logic                 valid;
        alu_op_e              alu_op;
        logic                 sgn;
        logic                 is_branch;
        branch_cond_e         branch_cond;
        logic                 is_load;
        logic [reg_idx_w-1:0] dest;
        logic [xlen-1:0]      pc;
        logic [xlen-1:0]      opr1;
        logic [xlen-1:0]      opr2;
        logic [xlen-1:0]      store_data;
    } decoded_t;

endpackage

`default_nettype wire

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import decode_pkg::*;
(
    input  wire logic            clk_stage,
    input  wire logic            rst,
    input  wire logic            stage_en,
    input  wire logic [xlen-1:0] instr,
    input  wire logic [xlen-1:0] pc,
    input  wire logic [xlen-1:0] rf_data1,
    input  wire logic [xlen-1:0] rf_data2,
    input  wire fwd_src_t        exe_fwd,
    input  wire fwd_src_t        mem_fwd,
    input  wire fwd_src_t        wb_fwd,
    input  wire logic [xlen-1:0] exe_result,
    input  wire logic [xlen-1:0] mem_result,
    output logic [reg_idx_w-1:0] rs1,
    output logic [reg_idx_w-1:0] rs2,
    output logic                 hold,
    output decoded_t             decoded
);

    ctrl_t           ctrl;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;

    // Raw source fields go straight to the register file ports
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];

    decode_control i_decode_control (
        .instr (instr),
        .ctrl  (ctrl)
    );

    imm_gen i_imm_gen (
        .instr (instr),
        .ctrl  (ctrl),
        .imm   (imm)
    );

    operand_forward i_operand_forward (
        .rs1        (rs1),
        .rs2        (rs2),
        .ctrl       (ctrl),
        .rf_data1   (rf_data1),
        .rf_data2   (rf_data2),
        .exe_fwd    (exe_fwd),
        .mem_fwd    (mem_fwd),
        .wb_fwd     (wb_fwd),
        .exe_result (exe_result),
        .mem_result (mem_result),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .hold       (hold)
    );

    decode_stage_reg i_decode_stage_reg (
        .clk_stage (clk_stage),
        .rst       (rst),
        .stage_en  (stage_en),
        .hold      (hold),
        .ctrl      (ctrl),
        .imm       (imm),
        .pc        (pc),
        .rs1_val   (rs1_val),
        .rs2_val   (rs2_val),
        .decoded   (decoded)
    );

endmodule

`default_nettype wire

// ==== logic/decode_stage_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage_reg
    import decode_pkg::*;
(
    input  wire logic            clk_stage,
    input  wire logic            rst,
    input  wire logic            stage_en,
    input  wire logic            hold,
    input  wire ctrl_t           ctrl,
    input  wire logic [xlen-1:0] imm,
    input  wire logic [xlen-1:0] pc,
    input  wire logic [xlen-1:0] rs1_val,
    input  wire logic [xlen-1:0] rs2_val,
    output decoded_t             decoded
);

    logic [xlen-1:0] opr1;
    logic [xlen-1:0] opr2;
    logic [xlen-1:0] store_data;
    logic            bubble;
    decoded_t        next_bundle;

    // Operand one, zero gives lui, pc gives auipc and jal
    always_comb begin
        case (ctrl.opa_sel)
            opa_zero: opr1 = '0;
            opa_pc:   opr1 = pc;
            default:  opr1 = rs1_val;
        endcase
    end

    // Operand two is rs2 only for op and branch
    assign opr2 = (ctrl.opb_sel == opb_rs2) ? rs2_val : imm;

    // Store data rides alongside the address operands
    assign store_data = ctrl.is_store ? rs2_val : '0;

    // Load-use stall and illegal word both leave an empty slot
    assign bubble = hold || !ctrl.valid;

    always_comb begin
        next_bundle.valid       = ctrl.valid;
        next_bundle.alu_op      = ctrl.alu_op;
        next_bundle.sgn         = ctrl.sgn;
        next_bundle.is_branch   = ctrl.is_branch;
        next_bundle.branch_cond = ctrl.branch_cond;
        next_bundle.is_load     = ctrl.is_load;
        next_bundle.dest        = ctrl.dest;
        next_bundle.pc          = pc;
        next_bundle.opr1        = opr1;
        next_bundle.opr2        = opr2;
        next_bundle.store_data  = store_data;
    end

    // Stage buffer toward EXE
    always_ff @(posedge clk_stage or negedge rst) begin
        if (!rst) begin
            decoded <= '0;
        end else if (stage_en) begin
            if (bubble) begin
                decoded <= '0;
            end else begin
                decoded <= next_bundle;
            end
        end
        // stage_en low keeps the buffer as it is
    end

endmodule

`default_nettype wire

// ==== logic/imm_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module imm_gen
    import decode_pkg::*;
(
    input  wire logic [xlen-1:0] instr,
    input  wire ctrl_t           ctrl,
    output logic [xlen-1:0]      imm
);

    opcode_e         opcode;
    logic            sign;
    logic [xlen-1:0] fmt_imm;

    assign opcode = opcode_e'(instr[6:0]);
    // All formats take their sign from bit 31
    assign sign   = instr[31];

    always_comb begin
        case (opcode)
            // I format
            op_imm, jalr, load: begin
                fmt_imm = {{20{sign}}, instr[31:20]};
            end
            // S format, low bits sit where rd would be
            store: begin
                fmt_imm = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            // B format, halfword aligned offset
            branch: begin
                fmt_imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            // U format, upper twenty bits with zero below
            lui, auipc: begin
                fmt_imm = {instr[31:12], 12'b0};
            end
            // J format, scrambled twenty-bit offset
            jal: begin
                fmt_imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            // R format has no immediate
            default: begin
                fmt_imm = '0;
            end
        endcase
    end

    // Nothing leaks out for an illegal word
    assign imm = ctrl.valid ? fmt_imm : '0;

endmodule

`default_nettype wire

// ==== logic/operand_forward.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_forward
    import decode_pkg::*;
(
    input  wire logic [reg_idx_w-1:0] rs1,
    input  wire logic [reg_idx_w-1:0] rs2,
    input  wire ctrl_t                ctrl,
    input  wire logic [xlen-1:0]      rf_data1,
    input  wire logic [xlen-1:0]      rf_data2,
    input  wire fwd_src_t             exe_fwd,
    input  wire fwd_src_t             mem_fwd,
    input  wire fwd_src_t             wb_fwd,
    input  wire logic [xlen-1:0]      exe_result,
    input  wire logic [xlen-1:0]      mem_result,
    output logic [xlen-1:0]           rs1_val,
    output logic [xlen-1:0]           rs2_val,
    output logic                      hold
);

    // Match flags, bit 0 EXE, bit 1 MEM
    logic [1:0] hit1;
    logic [1:0] hit2;
    logic       zero1;
    logic       zero2;
    logic       stall1;
    logic       stall2;

    // Youngest producer wins
    function automatic logic [xlen-1:0] pick(
        input logic            is_zero,
        input logic [1:0]      hit,
        input logic [xlen-1:0] rf_val,
        input logic [xlen-1:0] exe_val,
        input logic [xlen-1:0] mem_val
    );
        logic [xlen-1:0] res;
        if (is_zero) begin
            res = '0;
        end else if (hit[0]) begin
            res = exe_val;
        end else if (hit[1]) begin
            res = mem_val;
        end else begin
            // WB writes the register file ahead of this read
            res = rf_val;
        end
        return res;
    endfunction

    assign zero1 = (rs1 == '0);
    assign zero2 = (rs2 == '0);

    // Index comparators against EXE and MEM
    assign hit1 = {mem_fwd.dest == rs1, exe_fwd.dest == rs1};
    assign hit2 = {mem_fwd.dest == rs2, exe_fwd.dest == rs2};

    assign rs1_val = pick(zero1, hit1, rf_data1, exe_result, mem_result);
    assign rs2_val = pick(zero2, hit2, rf_data2, exe_result, mem_result);

    // Load in EXE has no data yet, only a used nonzero source waits for it
    assign stall1 = ctrl.rs1_used && !zero1 && hit1[0] && exe_fwd.is_load;
    assign stall2 = ctrl.rs2_used && !zero2 && hit2[0] && exe_fwd.is_load;

    assign hold = stall1 || stall2;

endmodule

`default_nettype wire
